// File: common/nand_cmd_params.svh
`ifndef NAND_CMD_PARAMS_SVH
`define NAND_CMD_PARAMS_SVH

// SPI clock timing
// SPI clock frequency is i_Clk / (2 x NAND_CLKS_PER_HALF_BIT), must be 2 or more
`define NAND_CLKS_PER_HALF_BIT 2

// Minimum time chip select stays high between two frames, in i_Clk cycles
`define NAND_CS_INACTIVE_CLKS  4

// Frame sizes
`define NAND_MAX_BYTES         4     // Longest kept command: opcode + 3 address bytes
`define NAND_CNT_W             3     // Wide enough to hold NAND_MAX_BYTES

// Host word holding row address, feature address or feature data
`define NAND_ADDR_W            24

`endif

// File: common/nand_cmd_pkg.sv
`include "nand_cmd_params.svh"

package nand_cmd_pkg;

    // Standard SPI NAND opcodes that the engine knows how to frame
    typedef enum logic [7:0] {
        OP_RESET         = 8'hFF,   // 1 byte
        OP_WRITE_ENABLE  = 8'h06,   // 1 byte
        OP_WRITE_DISABLE = 8'h04,   // 1 byte
        OP_GET_FEATURE   = 8'h0F,   // Opcode, feature addr, MISO data
        OP_SET_FEATURE   = 8'h1F,   // Opcode, feature addr, MOSI data
        OP_PAGE_READ     = 8'h13,   // Opcode + 24 bit row address
        OP_PROG_EXEC     = 8'h10,   // Opcode + 24 bit row address
        OP_BLOCK_ERASE   = 8'hD8    // Opcode + 24 bit row address
    } nand_opcode_e;

    // Command sequencer state
    typedef enum logic {
        SEQ_IDLE = 1'b0,            // Waiting for host command
        SEQ_BUSY = 1'b1             // Feeding remaining bytes of a frame
    } seq_state_e;

    // Command captured on the host valid pulse
    typedef struct packed {
        nand_opcode_e                 opcode;     // May hold an unlisted value
        logic [`NAND_ADDR_W-1:0]      addr_data;  // Address, data in low byte
        logic [`NAND_CNT_W-1:0]       num_bytes;  // Bytes in this frame
    } cmd_rec_t;

endpackage

// File: common/spi_byte_if.sv
`timescale 1ns/1ps
`include "nand_cmd_params.svh"

// Byte level link between command sequencer and SPI master
interface spi_byte_if (
    input logic i_Clk,
    input logic i_Rst_L
);

    // Sequencer to master
    logic [7:0]             tx_byte;    // Byte to shift out, valid with tx_dv
    logic                   tx_dv;      // One cycle pulse, only while tx_ready
    logic [`NAND_CNT_W-1:0] tx_count;   // Frame length, held for whole frame

    // Master to sequencer
    logic                   tx_ready;   // Master can take a byte
    logic [7:0]             rx_byte;    // Last byte seen on MISO
    logic                   rx_dv;      // One pulse per received byte
    logic [`NAND_CNT_W-1:0] rx_count;   // 1-based index of rx_byte in frame
    logic                   cs_n;       // Frame chip select, active low

    modport seq_mp (
        input  i_Clk, i_Rst_L,
        output tx_byte, tx_dv, tx_count,
        input  tx_ready, rx_byte, rx_dv, rx_count
    );

    modport spi_mp (
        input  i_Clk, i_Rst_L,
        input  tx_byte, tx_dv, tx_count,
        output tx_ready, rx_byte, rx_dv, rx_count, cs_n
    );

endinterface

// File: spi_master/spi_byte_master.sv
`timescale 1ns/1ps
`include "nand_cmd_params.svh"

// SPI mode 3 master that sends one chip select frame of tx_count bytes
// Clock idles high with MOSI moving on the falling edge and MISO sampled on the rising edge
module spi_byte_master (
    input  logic       i_Clk,
    input  logic       i_Rst_L,
    output logic       o_spi_clk,
    input  logic       i_spi_miso,
    output logic       o_spi_mosi,
    spi_byte_if.spi_mp bus
);

    localparam int HALF_BIT  = `NAND_CLKS_PER_HALF_BIT;
    localparam int CLK_CNT_W = $clog2(HALF_BIT);
    localparam int GAP_W     = $clog2(`NAND_CS_INACTIVE_CLKS + 1);

    localparam logic [CLK_CNT_W-1:0] HALF_LAST = CLK_CNT_W'(HALF_BIT - 1);
    localparam logic [GAP_W-1:0]     GAP_LOAD  = GAP_W'(`NAND_CS_INACTIVE_CLKS);
    localparam logic [4:0]           EDGES_PER_BYTE = 5'd16;   // 8 falling + 8 rising

    logic [CLK_CNT_W-1:0]   r_clk_cnt;      // i_Clk cycles within a half bit
    logic [4:0]             r_edges;        // SPI clock edges left in this byte
    logic                   r_byte_active;  // Byte loaded and not yet reported
    logic [7:0]             r_tx_shift;     // MSB goes out next
    logic [7:0]             r_rx_shift;     // MISO bits in MSB first order
    logic [`NAND_CNT_W-1:0] r_byte_cnt;     // Bytes loaded in this frame
    logic [GAP_W-1:0]       r_gap_cnt;      // CS high time still to serve
    logic                   r_spi_clk;
    logic                   r_mosi;
    logic                   r_cs_n;
    logic                   r_ready;
    logic [7:0]             r_rx_byte;
    logic                   r_rx_dv;
    logic [`NAND_CNT_W-1:0] r_rx_count;

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_clk_cnt     <= '0;
            r_edges       <= '0;
            r_byte_active <= 1'b0;
            r_byte_cnt    <= '0;
            r_gap_cnt     <= '0;
            r_spi_clk     <= 1'b1;                  // Mode 3 idle level
            r_mosi        <= 1'b0;
            r_cs_n        <= 1'b1;
            r_ready       <= 1'b1;
            r_rx_dv       <= 1'b0;
            r_rx_count    <= '0;
        end else begin
            r_rx_dv <= 1'b0;                        // Pulse by default

            if (bus.tx_dv && r_ready) begin
                // Start a byte and open the frame on the first one
                r_ready       <= 1'b0;
                r_cs_n        <= 1'b0;
                r_edges       <= EDGES_PER_BYTE;
                r_clk_cnt     <= '0;
                r_byte_active <= 1'b1;
                r_byte_cnt    <= r_byte_cnt + 1'b1;
            end else if (r_edges != 5'd0) begin
                if (r_clk_cnt == HALF_LAST) begin
                    r_clk_cnt <= '0;
                    r_edges   <= r_edges - 1'b1;
                    r_spi_clk <= ~r_spi_clk;
                    if (r_spi_clk)                  // Drive the next bit on the falling edge
                        r_mosi <= r_tx_shift[7];
                end else begin
                    r_clk_cnt <= r_clk_cnt + 1'b1;
                end
            end else if (r_byte_active) begin
                // Report the byte one cycle after the last rising edge
                r_byte_active <= 1'b0;
                r_rx_dv       <= 1'b1;
                r_rx_count    <= r_byte_cnt;        // 1-based index
                if (r_byte_cnt == bus.tx_count) begin
                    r_cs_n     <= 1'b1;             // Close the frame
                    r_gap_cnt  <= GAP_LOAD;
                    r_byte_cnt <= '0;
                end else begin
                    r_ready    <= 1'b1;             // More bytes to come in this frame
                end
            end else if (r_gap_cnt != '0) begin
                r_gap_cnt <= r_gap_cnt - 1'b1;
                if (r_gap_cnt == GAP_W'(1))
                    r_ready <= 1'b1;                // Gap served
            end
        end
    end

    // Shift registers of the data path
    always_ff @(posedge i_Clk) begin
        if (bus.tx_dv && r_ready) begin
            r_tx_shift <= bus.tx_byte;
        end else if (r_edges != 5'd0 && r_clk_cnt == HALF_LAST) begin
            if (r_spi_clk)
                r_tx_shift <= {r_tx_shift[6:0], 1'b0};      // Bit just driven
            else
                r_rx_shift <= {r_rx_shift[6:0], i_spi_miso}; // Sample on rising edge
        end
        if (r_edges == 5'd0 && r_byte_active && !(bus.tx_dv && r_ready))
            r_rx_byte <= r_rx_shift;
    end

    assign o_spi_clk    = r_spi_clk;
    assign o_spi_mosi   = r_mosi;
    assign bus.cs_n     = r_cs_n;
    assign bus.tx_ready = r_ready;
    assign bus.rx_byte  = r_rx_byte;
    assign bus.rx_dv    = r_rx_dv;
    assign bus.rx_count = r_rx_count;

    // No byte may be offered while the inactive gap is still counting
    a_cs_gap: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        (r_gap_cnt != '0) |-> !bus.tx_dv)
        else $error("byte offered during the chip select inactive gap");

endmodule

// File: verilog/nand_cmd_seq.sv
`timescale 1ns/1ps
`include "nand_cmd_params.svh"

// Turns a host command into the byte sequence of one SPI NAND frame
module nand_cmd_seq (
    input  logic                    i_Clk,
    input  logic                    i_Rst_L,
    input  logic [7:0]              i_command,
    input  logic                    i_cm_dv,
    input  logic [`NAND_ADDR_W-1:0] i_addr_data,
    output logic [7:0]              o_rx_feature_byte,
    output logic                    o_rx_feature_dv,
    spi_byte_if.seq_mp              bus
);

    localparam logic [`NAND_CNT_W-1:0] FEATURE_RX_IDX = `NAND_CNT_W'(3); // Flash drives byte 3

    nand_cmd_pkg::cmd_rec_t   r_cmd;        // Command in flight
    nand_cmd_pkg::seq_state_e r_state;
    nand_cmd_pkg::nand_opcode_e w_opcode;   // Host opcode as enum

    logic [`NAND_CNT_W-1:0] w_num_bytes;    // Frame length of the host opcode
    logic [`NAND_CNT_W-1:0] r_tx_idx;       // Bytes handed to the master so far
    logic [7:0]             w_next_byte;    // Byte at index r_tx_idx
    logic [7:0]             r_tx_byte;
    logic                   r_tx_dv;
    logic                   w_feature_hit;

    assign w_opcode = nand_cmd_pkg::nand_opcode_e'(i_command);

    // Frame length straight from the opcode, unknown opcodes go out alone
    always_comb begin
        case (w_opcode)
            nand_cmd_pkg::OP_RESET,
            nand_cmd_pkg::OP_WRITE_ENABLE,
            nand_cmd_pkg::OP_WRITE_DISABLE: w_num_bytes = `NAND_CNT_W'(1);
            nand_cmd_pkg::OP_GET_FEATURE,
            nand_cmd_pkg::OP_SET_FEATURE:   w_num_bytes = `NAND_CNT_W'(3);
            nand_cmd_pkg::OP_PAGE_READ,
            nand_cmd_pkg::OP_PROG_EXEC,
            nand_cmd_pkg::OP_BLOCK_ERASE:   w_num_bytes = `NAND_CNT_W'(`NAND_MAX_BYTES);
            default:                        w_num_bytes = `NAND_CNT_W'(1);
        endcase
    end

    // Capture the command, only ever loaded between frames
    always_ff @(posedge i_Clk) begin
        if (i_cm_dv) begin
            r_cmd.opcode    <= w_opcode;
            r_cmd.addr_data <= i_addr_data;
            r_cmd.num_bytes <= w_num_bytes;
        end
    end

    // Byte after the opcode, picked by command and position
    always_comb begin
        w_next_byte = 8'h00;
        case (r_cmd.opcode)
            nand_cmd_pkg::OP_GET_FEATURE,
            nand_cmd_pkg::OP_SET_FEATURE: begin
                if (r_tx_idx == `NAND_CNT_W'(1)) begin
                    w_next_byte = r_cmd.addr_data[15:8];           // Feature address
                end else if (r_cmd.opcode == nand_cmd_pkg::OP_SET_FEATURE) begin
                    w_next_byte = r_cmd.addr_data[7:0];            // Feature value
                end                                                // GET sends zero, flash talks
            end
            nand_cmd_pkg::OP_PAGE_READ,
            nand_cmd_pkg::OP_PROG_EXEC,
            nand_cmd_pkg::OP_BLOCK_ERASE: begin
                case (r_tx_idx)
                    `NAND_CNT_W'(1): w_next_byte = r_cmd.addr_data[23:16];
                    `NAND_CNT_W'(2): w_next_byte = r_cmd.addr_data[15:8];
                    default:         w_next_byte = r_cmd.addr_data[7:0];
                endcase
            end
            default: w_next_byte = 8'h00;
        endcase
    end

    // Byte issue FSM
    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_state   <= nand_cmd_pkg::SEQ_IDLE;
            r_tx_dv   <= 1'b0;
            r_tx_idx  <= '0;
            r_tx_byte <= 8'h00;
        end else begin
            r_tx_dv <= 1'b0;                                       // Pulse by default
            case (r_state)
                nand_cmd_pkg::SEQ_IDLE: begin
                    if (i_cm_dv && bus.tx_ready) begin
                        r_tx_dv   <= 1'b1;
                        r_tx_byte <= i_command;                    // Opcode first, no wait on r_cmd
                        r_tx_idx  <= `NAND_CNT_W'(1);
                        if (w_num_bytes != `NAND_CNT_W'(1))
                            r_state <= nand_cmd_pkg::SEQ_BUSY;
                    end
                end
                nand_cmd_pkg::SEQ_BUSY: begin
                    // Ready is still high in the cycle of our own pulse, skip it
                    if (bus.tx_ready && !r_tx_dv) begin
                        r_tx_dv   <= 1'b1;
                        r_tx_byte <= w_next_byte;
                        r_tx_idx  <= r_tx_idx + 1'b1;
                        if (r_tx_idx + 1'b1 == r_cmd.num_bytes)
                            r_state <= nand_cmd_pkg::SEQ_IDLE; // Last byte issued
                    end
                end
                default: r_state <= nand_cmd_pkg::SEQ_IDLE;
            endcase
        end
    end

    assign bus.tx_dv    = r_tx_dv;
    assign bus.tx_byte  = r_tx_byte;
    assign bus.tx_count = r_cmd.num_bytes;

    // GET_FEATURE data arrives as the third byte of the frame
    assign w_feature_hit = bus.rx_dv && (bus.rx_count == FEATURE_RX_IDX) &&
                           (r_cmd.opcode == nand_cmd_pkg::OP_GET_FEATURE);

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) o_rx_feature_dv <= 1'b0;
        else          o_rx_feature_dv <= w_feature_hit;
    end

    always_ff @(posedge i_Clk) begin
        if (w_feature_hit) o_rx_feature_byte <= bus.rx_byte;
    end

    // Master must still be ready in the cycle a byte is offered
    a_tx_dv_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        r_tx_dv |-> bus.tx_ready)
        else $error("tx_dv issued while SPI master not ready");

    // Host must wait for the frame in flight
    a_host_busy: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        i_cm_dv |-> (r_state == nand_cmd_pkg::SEQ_IDLE) && bus.tx_ready)
        else $error("i_cm_dv while a command is in flight");

endmodule

// File: verilog/nand_cmd_top.sv
`timescale 1ns/1ps

// SPI NAND command engine
// Host command in, one chip select frame out per command
module nand_cmd_top (
    input  logic        i_Clk,
    input  logic        i_Rst_L,

    // Host command port
    input  logic [7:0]  i_command,          // Opcode
    input  logic        i_cm_dv,            // Pulse only while o_cm_ready is high
    input  logic [23:0] i_addr_data,        // Row address or feature addr/data
    output logic        o_cm_ready,         // High when a new command can start

    // SPI pins, mode 3
    output logic        o_spi_clk,
    input  logic        i_spi_miso,
    output logic        o_spi_mosi,
    output logic        o_spi_cs_n,

    // GET_FEATURE result
    output logic [7:0]  o_rx_feature_byte,
    output logic        o_rx_feature_dv     // One cycle pulse per GET_FEATURE
);

    spi_byte_if bus_if (
        .i_Clk   (i_Clk),
        .i_Rst_L (i_Rst_L)
    );

    // Builds the byte stream of each command
    nand_cmd_seq u_seq (
        .i_Clk             (i_Clk),
        .i_Rst_L           (i_Rst_L),
        .i_command         (i_command),
        .i_cm_dv           (i_cm_dv),
        .i_addr_data       (i_addr_data),
        .o_rx_feature_byte (o_rx_feature_byte),
        .o_rx_feature_dv   (o_rx_feature_dv),
        .bus               (bus_if.seq_mp)
    );

    // Serializes bytes and frames them with chip select
    spi_byte_master u_spi (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .o_spi_clk  (o_spi_clk),
        .i_spi_miso (i_spi_miso),
        .o_spi_mosi (o_spi_mosi),
        .bus        (bus_if.spi_mp)
    );

    assign o_spi_cs_n = bus_if.cs_n;

    // Ready drops the moment the host pulses and stays low until the gap after CS ends
    // tx_dv covers the one cycle before the master's ready register falls
    assign o_cm_ready = bus_if.cs_n & bus_if.tx_ready & ~bus_if.tx_dv & ~i_cm_dv;

endmodule

// File: verif/spi_flash_model.sv
`timescale 1ns/1ps

// Passive SPI NAND stand-in, mode 3
// Collects MOSI bytes per chip select frame and drives MISO during byte 3
module spi_flash_model (
    input  logic        i_spi_clk,
    input  logic        i_spi_cs_n,
    input  logic        i_spi_mosi,
    input  logic [7:0]  i_miso_byte,     // Feature value returned in byte 3
    output logic        o_spi_miso,
    output logic [31:0] o_frame_bytes,   // Byte 0 in bits 31:24
    output logic [7:0]  o_byte_count,
    output int          o_frame_count    // Bumps once per closed frame
);

    int          bit_cnt = 0;            // Rising edges seen in this frame
    logic [7:0]  shreg = 8'h00;
    logic [31:0] bytes = 32'h0;

    initial begin
        o_spi_miso    = 1'b0;
        o_frame_bytes = 32'h0;
        o_byte_count  = 8'h00;
        o_frame_count = 0;
    end

    // Sample MOSI on rising SCK, report the frame when CS rises
    always @(posedge i_spi_clk or posedge i_spi_cs_n) begin
        if (i_spi_cs_n) begin
            if (bit_cnt != 0) begin     // Skip the reset edge of CS
                o_frame_bytes <= bytes;
                o_byte_count  <= 8'(bit_cnt / 8);
                o_frame_count <= o_frame_count + 1;
            end
            bit_cnt = 0;
            bytes   = 32'h0;
        end else begin
            shreg = {shreg[6:0], i_spi_mosi};   // MSB first
            if ((bit_cnt % 8 == 7) && (bit_cnt < 32))
                bytes[31 - 8 * (bit_cnt / 8) -: 8] = shreg;
            bit_cnt = bit_cnt + 1;
        end
    end

    // Drive on falling SCK so the bit is settled before the master samples
    always @(negedge i_spi_clk) begin
        if (!i_spi_cs_n && (bit_cnt / 8 == 2))
            o_spi_miso <= i_miso_byte[7 - bit_cnt % 8];
        else
            o_spi_miso <= 1'b0;         // Flash quiet outside byte 3
    end

endmodule

// File: verif/tb_nand_cmd.sv
`timescale 1ns/1ps
`include "nand_cmd_params.svh"

module tb_nand_cmd;

    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 4 * 16 * 2 + 4 + 20;  // Longest frame plus gap and slack

    logic        i_Clk;
    logic        i_Rst_L;
    logic [7:0]  i_command;
    logic        i_cm_dv;
    logic [23:0] i_addr_data;
    logic        o_cm_ready;
    logic        o_spi_clk;
    logic        spi_miso;
    logic        o_spi_mosi;
    logic        o_spi_cs_n;
    logic [7:0]  o_rx_feature_byte;
    logic        o_rx_feature_dv;

    logic [7:0]  miso_byte;             // Byte the flash returns this test
    logic [31:0] frame_bytes;
    logic [7:0]  byte_count;
    int          frame_count;

    // Test table loaded from the data file
    logic [7:0]  t_op   [MAX_TESTS];
    logic [23:0] t_addr [MAX_TESTS];
    logic [7:0]  t_miso [MAX_TESTS];
    logic [7:0]  t_cnt  [MAX_TESTS];
    logic [31:0] t_exp  [MAX_TESTS];    // Expected MOSI, byte 0 on top

    int          num_tests      = 0;
    int          errors         = 0;
    int          checks         = 0;
    int          cycles         = 0;
    int          cycle_limit    = 0;    // Zero until the table is read
    int          feature_pulses = 0;
    logic [7:0]  feature_seen   = 8'h00;

    nand_cmd_top DUT (
        .i_Clk             (i_Clk),
        .i_Rst_L           (i_Rst_L),
        .i_command         (i_command),
        .i_cm_dv           (i_cm_dv),
        .i_addr_data       (i_addr_data),
        .o_cm_ready        (o_cm_ready),
        .o_spi_clk         (o_spi_clk),
        .i_spi_miso        (spi_miso),
        .o_spi_mosi        (o_spi_mosi),
        .o_spi_cs_n        (o_spi_cs_n),
        .o_rx_feature_byte (o_rx_feature_byte),
        .o_rx_feature_dv   (o_rx_feature_dv)
    );

    spi_flash_model u_flash (
        .i_spi_clk     (o_spi_clk),
        .i_spi_cs_n    (o_spi_cs_n),
        .i_spi_mosi    (o_spi_mosi),
        .i_miso_byte   (miso_byte),
        .o_spi_miso    (spi_miso),
        .o_frame_bytes (frame_bytes),
        .o_byte_count  (byte_count),
        .o_frame_count (frame_count)
    );

    initial begin
        i_Clk = 1'b0;
        forever #2 i_Clk = ~i_Clk;      // 4 ns period
    end

    // Feature pulses and run length watchdog
    always @(posedge i_Clk) begin
        cycles = cycles + 1;
        if (o_rx_feature_dv === 1'b1) begin
            feature_pulses = feature_pulses + 1;
            feature_seen   = o_rx_feature_byte;
        end
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a command never completed", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    // Columns: opcode addr_data miso_byte byte_count mosi0 mosi1 mosi2 mosi3
    task automatic read_tests;
        int                 fd;
        int                 n;
        int                 op, ad, mi, cn, b0, b1, b2, b3;
        logic [8*128-1:0]   line;
        fd = $fopen("verif/nand_cmd_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/nand_cmd_tests.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                op, ad, mi, cn, b0, b1, b2, b3);
                    if (n == 8) begin           // Comment and blank lines fall through
                        t_op[num_tests]   = op[7:0];
                        t_addr[num_tests] = ad[23:0];
                        t_miso[num_tests] = mi[7:0];
                        t_cnt[num_tests]  = cn[7:0];
                        t_exp[num_tests]  = {b0[7:0], b1[7:0], b2[7:0], b3[7:0]};
                        num_tests = num_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One command, called on a falling edge
    task automatic run_test(input int idx);
        int frames_before;
        int feat_before;
        int gap;
        while (o_cm_ready !== 1'b1) @(negedge i_Clk);
        miso_byte     = t_miso[idx];
        frames_before = frame_count;
        feat_before   = feature_pulses;
        i_command     = t_op[idx];
        i_addr_data   = t_addr[idx];
        i_cm_dv       = 1'b1;
        @(negedge i_Clk);
        i_cm_dv = 1'b0;
        // Busy until the flash sees CS rise
        while (frame_count == frames_before) begin
            check_val("o_cm_ready", 32'(o_cm_ready), 32'h0);
            @(negedge i_Clk);
        end
        gap = 0;
        while (o_cm_ready !== 1'b1) begin
            if (o_spi_cs_n === 1'b1) gap = gap + 1;
            @(negedge i_Clk);
        end
        if (gap < `NAND_CS_INACTIVE_CLKS) begin
            errors = errors + 1;
            $display("Test %0d: chip select high only %0d cycles before ready", idx, gap);
        end
        check_val("byte_count", 32'(byte_count), 32'(t_cnt[idx]));
        for (int k = 0; k < 4; k++) begin
            if (k < int'(t_cnt[idx]))
                check_val($sformatf("mosi_byte%0d", k), 32'(frame_bytes[31 - 8 * k -: 8]),
                          32'(t_exp[idx][31 - 8 * k -: 8]));
        end
        if (t_op[idx] == 8'h0F) begin
            check_val("o_rx_feature_dv", 32'(feature_pulses - feat_before), 32'h1);
            check_val("o_rx_feature_byte", 32'(feature_seen), 32'(t_miso[idx]));
        end else begin
            check_val("o_rx_feature_dv", 32'(feature_pulses - feat_before), 32'h0);
        end
    endtask

    initial begin
        i_Rst_L     = 1'b0;
        i_command   = 8'h00;
        i_cm_dv     = 1'b0;
        i_addr_data = 24'h0;
        miso_byte   = 8'h00;
        read_tests();
        cycle_limit = num_tests * CYCLES_PER_TEST;
        repeat (2) @(posedge i_Clk);
        @(negedge i_Clk);
        i_Rst_L = 1'b1;
        @(negedge i_Clk);
        // Idle levels straight after reset
        check_val("o_spi_cs_n", 32'(o_spi_cs_n), 32'h1);
        check_val("o_spi_clk", 32'(o_spi_clk), 32'h1);
        check_val("o_cm_ready", 32'(o_cm_ready), 32'h1);
        check_val("o_rx_feature_dv", 32'(o_rx_feature_dv), 32'h0);
        for (int i = 0; i < num_tests; i++)
            run_test(i);
        if (num_tests == 0) begin
            errors = errors + 1;
            $display("No tests were loaded");
        end
        $display("Errors: %0d in %0d checks over %0d tests", errors, checks, num_tests);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verif/nand_cmd_tests.txt
# opcode addr_data miso_byte byte_count mosi0 mosi1 mosi2 mosi3 (all hex)
# unused mosi columns are 00
FF 000000 00 1 FF 00 00 00
06 000000 00 1 06 00 00 00
04 000000 00 1 04 00 00 00
0F 00C000 A5 3 0F C0 00 00
1F 00A07C 77 3 1F A0 7C 00
13 012345 00 4 13 01 23 45
10 00ABCD 00 4 10 00 AB CD
D8 7F0040 00 4 D8 7F 00 40
9F 123456 00 1 9F 00 00 00
0F 00B05A 3C 3 0F B0 00 00
1F 00B018 5A 3 1F B0 18 00
13 FFFFFF 00 4 13 FF FF FF

// File: verilog.f
+incdir+common
common/nand_cmd_pkg.sv
common/spi_byte_if.sv
spi_master/spi_byte_master.sv
verilog/nand_cmd_seq.sv
verilog/nand_cmd_top.sv
verif/spi_flash_model.sv
verif/tb_nand_cmd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI NAND command engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_nand_cmd \
    && ./obj_dir/Vtb_nand_cmd | tee /dev/stderr | grep -q "sim passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
